// ==== hw/rf_cfg.svh ====
`ifndef RF_CFG_SVH
`define RF_CFG_SVH

// register file geometry
`define RF_WIDTH   16
`define RF_REGS    32
`define RF_ADDR_W  5

// four banks interleaved on the low address bits
`define RF_BANKS   4
`define RF_SEL_W   2
`define RF_LOCAL_W 3

`define RF_OP_W    2

`endif

// ==== hw/rf_pkg.sv ====
`include "rf_cfg.svh"

package rf_pkg;

   // command opcodes
   typedef enum logic [`RF_OP_W-1:0] {
      OP_WRITE = 2'd0,
      OP_ADD   = 2'd1,
      OP_SUB   = 2'd2,
      OP_XOR   = 2'd3
   } op_e;

endpackage

// ==== hw/rf_bank.sv ====
`timescale 1ns/1ps

// two read ports, one write port, synchronous reads
module rf_bank #(
   parameter int WIDTH = 16,
   parameter int DEPTH = 8
) (
   input  logic                     clk_i,

   input  logic                     w_v_i,
   input  logic [$clog2(DEPTH)-1:0] w_addr_i,
   input  logic [WIDTH-1:0]         w_data_i,

   input  logic                     r0_v_i,
   input  logic [$clog2(DEPTH)-1:0] r0_addr_i,
   output logic [WIDTH-1:0]         r0_data_o,

   input  logic                     r1_v_i,
   input  logic [$clog2(DEPTH)-1:0] r1_addr_i,
   output logic [WIDTH-1:0]         r1_data_o
);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [WIDTH-1:0] r0_data_q;
   logic [WIDTH-1:0] r1_data_q;

   // storage array written at the edge
   always_ff @(posedge clk_i)
   begin
      if (w_v_i)
      begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // a read at the write edge sees the old word
   // outputs hold while the read valid is low
   always_ff @(posedge clk_i)
   begin
      if (r0_v_i)
      begin
         r0_data_q <= mem[r0_addr_i];
      end
      if (r1_v_i)
      begin
         r1_data_q <= mem[r1_addr_i];
      end
   end

   assign r0_data_o = r0_data_q;
   assign r1_data_o = r1_data_q;

endmodule

// ==== hw/rf_dispatch.sv ====
`timescale 1ns/1ps

`include "rf_cfg.svh"

module rf_dispatch (
   input  logic                                       clk_i,
   input  logic                                       rst_n_i,

   input  logic                                       cmd_v_i,
   input  rf_pkg::op_e                                cmd_op_i,
   input  logic [`RF_ADDR_W-1:0]                      cmd_dst_i,
   input  logic [`RF_ADDR_W-1:0]                      cmd_src0_i,
   input  logic [`RF_ADDR_W-1:0]                      cmd_src1_i,
   input  logic [`RF_WIDTH-1:0]                       cmd_imm_i,

   input  logic                                       wb_v_i,
   input  logic [`RF_ADDR_W-1:0]                      wb_addr_i,
   input  logic [`RF_WIDTH-1:0]                       wb_data_i,

   output logic [`RF_BANKS-1:0]                       bank_r0_v_o,
   output logic [`RF_BANKS-1:0][`RF_LOCAL_W-1:0]      bank_r0_addr_o,
   output logic [`RF_BANKS-1:0]                       bank_r1_v_o,
   output logic [`RF_BANKS-1:0][`RF_LOCAL_W-1:0]      bank_r1_addr_o,
   output logic [`RF_BANKS-1:0]                       bank_w_v_o,
   output logic [`RF_BANKS-1:0][`RF_LOCAL_W-1:0]      bank_w_addr_o,
   output logic [`RF_BANKS-1:0][`RF_WIDTH-1:0]        bank_w_data_o,

   output logic                                       stage_v_o,
   output rf_pkg::op_e                                stage_op_o,
   output logic [`RF_ADDR_W-1:0]                      stage_dst_o,
   output logic [`RF_WIDTH-1:0]                       stage_imm_o,
   output logic [`RF_SEL_W-1:0]                       stage_sel0_o,
   output logic [`RF_SEL_W-1:0]                       stage_sel1_o,
   output logic                                       byp0_o,
   output logic                                       byp1_o
);

   logic [`RF_SEL_W-1:0] sel0;
   logic [`RF_SEL_W-1:0] sel1;
   logic [`RF_SEL_W-1:0] wsel;
   logic                 rd_en;
   logic                 byp0_d;
   logic                 byp1_d;

   // low bits pick the bank, high bits the entry inside it
   assign sel0  = cmd_src0_i[`RF_SEL_W-1:0];
   assign sel1  = cmd_src1_i[`RF_SEL_W-1:0];
   assign wsel  = wb_addr_i[`RF_SEL_W-1:0];

   // write immediate has no sources
   assign rd_en = cmd_v_i && (cmd_op_i != rf_pkg::OP_WRITE);

   always_comb
   begin
      for (int b = 0; b < `RF_BANKS; b++)
      begin
         bank_r0_v_o[b]    = rd_en && (sel0 == `RF_SEL_W'(b));
         bank_r0_addr_o[b] = cmd_src0_i[`RF_ADDR_W-1:`RF_SEL_W];
         bank_r1_v_o[b]    = rd_en && (sel1 == `RF_SEL_W'(b));
         bank_r1_addr_o[b] = cmd_src1_i[`RF_ADDR_W-1:`RF_SEL_W];
         bank_w_v_o[b]     = wb_v_i && (wsel == `RF_SEL_W'(b));
         bank_w_addr_o[b]  = wb_addr_i[`RF_ADDR_W-1:`RF_SEL_W];
         bank_w_data_o[b]  = wb_data_i;
      end
   end

   // the write in flight lands at the same edge as these reads,
   // and the bank returns the old word, so take it from the collector
   assign byp0_d = wb_v_i && (cmd_src0_i == wb_addr_i);
   assign byp1_d = wb_v_i && (cmd_src1_i == wb_addr_i);

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         stage_v_o <= 1'b0;
      end
      else
      begin
         stage_v_o <= cmd_v_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      stage_op_o   <= cmd_op_i;
      stage_dst_o  <= cmd_dst_i;
      stage_imm_o  <= cmd_imm_i;
      stage_sel0_o <= sel0;
      stage_sel1_o <= sel1;
      byp0_o       <= byp0_d;
      byp1_o       <= byp1_d;
   end

endmodule

// ==== hw/rf_collect.sv ====
`timescale 1ns/1ps

`include "rf_cfg.svh"

module rf_collect (
   input  logic                                  clk_i,
   input  logic                                  rst_n_i,

   input  logic                                  stage_v_i,
   input  rf_pkg::op_e                           stage_op_i,
   input  logic [`RF_ADDR_W-1:0]                 stage_dst_i,
   input  logic [`RF_WIDTH-1:0]                  stage_imm_i,
   input  logic [`RF_SEL_W-1:0]                  stage_sel0_i,
   input  logic [`RF_SEL_W-1:0]                  stage_sel1_i,
   input  logic                                  byp0_i,
   input  logic                                  byp1_i,

   input  logic [`RF_BANKS-1:0][`RF_WIDTH-1:0]   bank_r0_data_i,
   input  logic [`RF_BANKS-1:0][`RF_WIDTH-1:0]   bank_r1_data_i,

   output logic                                  wb_v_o,
   output logic [`RF_ADDR_W-1:0]                 wb_addr_o,
   output logic [`RF_WIDTH-1:0]                  wb_data_o,

   output logic                                  res_v_o,
   output logic [`RF_WIDTH-1:0]                  res_data_o
);

   logic [`RF_WIDTH-1:0] opa;
   logic [`RF_WIDTH-1:0] opb;
   logic [`RF_WIDTH-1:0] result;
   logic [`RF_WIDTH-1:0] last_wb_q;
   logic                 res_v_q;
   logic [`RF_WIDTH-1:0] res_data_q;

   // forwarded data wins over the bank
   assign opa = byp0_i ? last_wb_q : bank_r0_data_i[stage_sel0_i];
   assign opb = byp1_i ? last_wb_q : bank_r1_data_i[stage_sel1_i];

   always_comb
   begin
      case (stage_op_i)
         rf_pkg::OP_WRITE: result = stage_imm_i;
         rf_pkg::OP_ADD:   result = opa + opb;
         // wraps modulo 2^16
         rf_pkg::OP_SUB:   result = opa - opb;
         rf_pkg::OP_XOR:   result = opa ^ opb;
         default:          result = stage_imm_i;
      endcase
   end

   // writeback goes straight back to the dispatcher this cycle
   assign wb_v_o    = stage_v_i;
   assign wb_addr_o = stage_dst_i;
   assign wb_data_o = result;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         res_v_q <= 1'b0;
      end
      else
      begin
         res_v_q <= stage_v_i;
      end
   end

   // last written value feeds the next command when its source matches
   always_ff @(posedge clk_i)
   begin
      res_data_q <= result;
      if (stage_v_i)
      begin
         last_wb_q <= result;
      end
   end

   assign res_v_o    = res_v_q;
   assign res_data_o = res_data_q;

endmodule

// ==== hw/rf_engine_top.sv ====
`timescale 1ns/1ps

`include "rf_cfg.svh"

module rf_engine_top (
   input  logic                    clk_i,
   input  logic                    rst_n_i,

   input  logic                    cmd_v_i,
   input  rf_pkg::op_e             cmd_op_i,
   input  logic [`RF_ADDR_W-1:0]   cmd_dst_i,
   input  logic [`RF_ADDR_W-1:0]   cmd_src0_i,
   input  logic [`RF_ADDR_W-1:0]   cmd_src1_i,
   input  logic [`RF_WIDTH-1:0]    cmd_imm_i,

   output logic                    res_v_o,
   output logic [`RF_WIDTH-1:0]    res_data_o
);

   // dispatcher to banks
   logic [`RF_BANKS-1:0]                    bank_r0_v;
   logic [`RF_BANKS-1:0][`RF_LOCAL_W-1:0]   bank_r0_addr;
   logic [`RF_BANKS-1:0]                    bank_r1_v;
   logic [`RF_BANKS-1:0][`RF_LOCAL_W-1:0]   bank_r1_addr;
   logic [`RF_BANKS-1:0]                    bank_w_v;
   logic [`RF_BANKS-1:0][`RF_LOCAL_W-1:0]   bank_w_addr;
   logic [`RF_BANKS-1:0][`RF_WIDTH-1:0]     bank_w_data;

   // banks to collector
   logic [`RF_BANKS-1:0][`RF_WIDTH-1:0]     bank_r0_data;
   logic [`RF_BANKS-1:0][`RF_WIDTH-1:0]     bank_r1_data;

   // dispatcher to collector
   logic                    stage_v;
   rf_pkg::op_e             stage_op;
   logic [`RF_ADDR_W-1:0]   stage_dst;
   logic [`RF_WIDTH-1:0]    stage_imm;
   logic [`RF_SEL_W-1:0]    stage_sel0;
   logic [`RF_SEL_W-1:0]    stage_sel1;
   logic                    byp0;
   logic                    byp1;

   // writeback loop
   logic                    wb_v;
   logic [`RF_ADDR_W-1:0]   wb_addr;
   logic [`RF_WIDTH-1:0]    wb_data;

   rf_dispatch u_rf_dispatch (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .cmd_v_i        (cmd_v_i),
      .cmd_op_i       (cmd_op_i),
      .cmd_dst_i      (cmd_dst_i),
      .cmd_src0_i     (cmd_src0_i),
      .cmd_src1_i     (cmd_src1_i),
      .cmd_imm_i      (cmd_imm_i),
      .wb_v_i         (wb_v),
      .wb_addr_i      (wb_addr),
      .wb_data_i      (wb_data),
      .bank_r0_v_o    (bank_r0_v),
      .bank_r0_addr_o (bank_r0_addr),
      .bank_r1_v_o    (bank_r1_v),
      .bank_r1_addr_o (bank_r1_addr),
      .bank_w_v_o     (bank_w_v),
      .bank_w_addr_o  (bank_w_addr),
      .bank_w_data_o  (bank_w_data),
      .stage_v_o      (stage_v),
      .stage_op_o     (stage_op),
      .stage_dst_o    (stage_dst),
      .stage_imm_o    (stage_imm),
      .stage_sel0_o   (stage_sel0),
      .stage_sel1_o   (stage_sel1),
      .byp0_o         (byp0),
      .byp1_o         (byp1)
   );

   for (genvar b = 0; b < `RF_BANKS; b++)
   begin : g_bank
      rf_bank #(
         .WIDTH (`RF_WIDTH),
         .DEPTH (`RF_REGS / `RF_BANKS)
      ) u_rf_bank (
         .clk_i     (clk_i),
         .w_v_i     (bank_w_v[b]),
         .w_addr_i  (bank_w_addr[b]),
         .w_data_i  (bank_w_data[b]),
         .r0_v_i    (bank_r0_v[b]),
         .r0_addr_i (bank_r0_addr[b]),
         .r0_data_o (bank_r0_data[b]),
         .r1_v_i    (bank_r1_v[b]),
         .r1_addr_i (bank_r1_addr[b]),
         .r1_data_o (bank_r1_data[b])
      );
   end

   rf_collect u_rf_collect (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .stage_v_i      (stage_v),
      .stage_op_i     (stage_op),
      .stage_dst_i    (stage_dst),
      .stage_imm_i    (stage_imm),
      .stage_sel0_i   (stage_sel0),
      .stage_sel1_i   (stage_sel1),
      .byp0_i         (byp0),
      .byp1_i         (byp1),
      .bank_r0_data_i (bank_r0_data),
      .bank_r1_data_i (bank_r1_data),
      .wb_v_o         (wb_v),
      .wb_addr_o      (wb_addr),
      .wb_data_o      (wb_data),
      .res_v_o        (res_v_o),
      .res_data_o     (res_data_o)
   );

endmodule

// ==== sim/rf_engine_chk.sv ====
`timescale 1ns/1ps

`include "rf_cfg.svh"

module rf_engine_chk (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 cmd_v_i,
   input  logic                 res_v_i,
   input  logic [`RF_WIDTH-1:0] res_data_i
);

   // one result per command after a fixed latency of two edges
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    res_v_i == $past(cmd_v_i, 2))
      else $error("result strobe does not follow the command by two cycles");

   // synchronous reset clears the strobe at the next edge
   assert property (@(posedge clk_i) !rst_n_i |=> !res_v_i)
      else $error("result strobe high during reset");

   assert property (@(posedge clk_i) disable iff (!rst_n_i)
                    res_v_i |-> !$isunknown(res_data_i))
      else $error("result data has unknown bits while valid");

endmodule

bind rf_engine_top rf_engine_chk u_rf_engine_chk (
   .clk_i      (clk_i),
   .rst_n_i    (rst_n_i),
   .cmd_v_i    (cmd_v_i),
   .res_v_i    (res_v_o),
   .res_data_i (res_data_o)
);

// ==== sim/rf_engine_tb.sv ====
`timescale 1ns/1ps

`include "rf_cfg.svh"

module rf_engine_tb;

   logic                  clk_i;
   logic                  rst_n_i;
   logic                  cmd_v_i;
   rf_pkg::op_e           cmd_op_i;
   logic [`RF_ADDR_W-1:0] cmd_dst_i;
   logic [`RF_ADDR_W-1:0] cmd_src0_i;
   logic [`RF_ADDR_W-1:0] cmd_src1_i;
   logic [`RF_WIDTH-1:0]  cmd_imm_i;
   logic                  res_v_o;
   logic [`RF_WIDTH-1:0]  res_data_o;

   // expected results in command order
   logic [`RF_WIDTH-1:0]  exp_q [$];
   int                    n_cmd;
   int                    n_res;

   rf_engine_top u_rf_engine_top (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .cmd_v_i    (cmd_v_i),
      .cmd_op_i   (cmd_op_i),
      .cmd_dst_i  (cmd_dst_i),
      .cmd_src0_i (cmd_src0_i),
      .cmd_src1_i (cmd_src1_i),
      .cmd_imm_i  (cmd_imm_i),
      .res_v_o    (res_v_o),
      .res_data_o (res_data_o)
   );

   always #10 clk_i = ~clk_i;

   task automatic compare_value(input string name, input logic [`RF_WIDTH-1:0] got,
                                input logic [`RF_WIDTH-1:0] exp);
      if (got !== exp)
      begin
         $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
         $display("Test failures found");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   // each result strobe is checked on the falling edge
   always @(negedge clk_i)
   begin
      if (rst_n_i && res_v_o)
      begin
         if (exp_q.size() == 0)
         begin
            $display("Test failures found");
            $fatal(1, "result strobe at %0t with no command outstanding", $time);
         end
         else
         begin
            compare_value("res_data_o", res_data_o, exp_q.pop_front());
            n_res++;
         end
      end
   end

   initial
   begin
      int    fd;
      int    nf;
      int    f_gap;
      int    f_op;
      int    f_dst;
      int    f_src0;
      int    f_src1;
      int    f_imm;
      int    f_exp;
      int    wait_cycles;
      string line;

      clk_i      = 1'b0;
      rst_n_i    = 1'b0;
      cmd_v_i    = 1'b0;
      cmd_op_i   = rf_pkg::OP_WRITE;
      cmd_dst_i  = '0;
      cmd_src0_i = '0;
      cmd_src1_i = '0;
      cmd_imm_i  = '0;
      n_cmd      = 0;
      n_res      = 0;

      repeat (3) @(posedge clk_i);
      rst_n_i <= 1'b1;

      fd = $fopen("sim/rf_engine_vectors.txt", "r");
      if (fd == 0)
      begin
         $display("Test failures found");
         $fatal(1, "cannot open the vector file");
      end

      while ($fgets(line, fd) != 0)
      begin
         // skip comment and empty lines
         if (line.len() < 2 || line.getc(0) == "#")
         begin
            continue;
         end
         nf = $sscanf(line, "%h %h %h %h %h %h %h",
                      f_gap, f_op, f_dst, f_src0, f_src1, f_imm, f_exp);
         if (nf != 7)
         begin
            $display("Test failures found");
            $fatal(1, "malformed vector line %s", line);
         end
         if (f_gap != 0)
         begin
            @(posedge clk_i);
            cmd_v_i <= 1'b0;
         end
         @(posedge clk_i);
         cmd_v_i    <= 1'b1;
         cmd_op_i   <= rf_pkg::op_e'(f_op[`RF_OP_W-1:0]);
         cmd_dst_i  <= f_dst[`RF_ADDR_W-1:0];
         cmd_src0_i <= f_src0[`RF_ADDR_W-1:0];
         cmd_src1_i <= f_src1[`RF_ADDR_W-1:0];
         cmd_imm_i  <= f_imm[`RF_WIDTH-1:0];
         exp_q.push_back(f_exp[`RF_WIDTH-1:0]);
         n_cmd++;
      end
      $fclose(fd);

      @(posedge clk_i);
      cmd_v_i <= 1'b0;

      // drain the two commands still in flight
      wait_cycles = 0;
      while (n_res < n_cmd && wait_cycles < 20)
      begin
         @(posedge clk_i);
         wait_cycles++;
      end

      if (n_res == n_cmd && exp_q.size() == 0)
      begin
         $display("All tests passed!");
         $finish;
      end
      else
      begin
         $display("Test failures found");
         $fatal(1, "results went missing, got %0d of %0d", n_res, n_cmd);
      end
   end

endmodule

// ==== sim/rf_engine_vectors.txt ====
# gap op dst src0 src1 imm expected, all hex
# op 0 write 1 add 2 sub 3 xor, gap 1 inserts one idle cycle before the command
0 0 00 00 00 1000 1000
0 0 01 00 00 0005 0005
0 0 02 00 00 0007 0007
0 0 03 00 00 a5a5 a5a5
0 0 04 00 00 1004 1004
0 0 05 00 00 fff0 fff0
0 0 06 00 00 0020 0020
0 0 07 00 00 0ff0 0ff0
0 0 08 00 00 1008 1008
0 0 09 00 00 1009 1009
0 0 0a 00 00 100a 100a
0 0 0b 00 00 100b 100b
0 0 0c 00 00 100c 100c
0 0 0d 00 00 100d 100d
0 0 0e 00 00 100e 100e
0 0 0f 00 00 100f 100f
0 0 10 00 00 1010 1010
0 0 11 00 00 1011 1011
0 0 12 00 00 1012 1012
0 0 13 00 00 1013 1013
0 0 14 00 00 1014 1014
0 0 15 00 00 1015 1015
0 0 16 00 00 1016 1016
0 0 17 00 00 1017 1017
0 0 18 00 00 1018 1018
0 0 19 00 00 1019 1019
0 0 1a 00 00 101a 101a
0 0 1b 00 00 101b 101b
0 0 1c 00 00 101c 101c
0 0 1d 00 00 101d 101d
0 0 1e 00 00 101e 101e
0 0 1f 00 00 101f 101f
1 1 08 05 06 0000 0010
1 2 09 01 02 0000 fffe
1 3 0a 03 07 0000 aa55
1 2 0b 02 01 0000 0002
1 1 0c 08 09 0000 000e
0 1 0d 0c 0b 0000 0010
0 3 0e 0a 0d 0000 aa45
0 2 0f 0e 0e 0000 0000
0 0 10 00 00 1234 1234
0 1 11 10 0c 0000 1242
0 2 12 0d 11 0000 edce
0 3 13 11 12 0000 ff8c
1 1 14 04 08 0000 1014
1 1 15 09 09 0000 fffc
1 3 16 0e 12 0000 478b
0 2 17 16 0a 0000 9d36
1 3 18 1f 1e 0000 0001

// ==== build.f ====
+incdir+hw
hw/rf_pkg.sv
hw/rf_bank.sv
hw/rf_dispatch.sv
hw/rf_collect.sv
hw/rf_engine_top.sv
sim/rf_engine_chk.sv
sim/rf_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module rf_engine_tb -o rf_engine_sim
./obj_dir/rf_engine_sim
